//--- build.f
rtl/soc_pkg.sv
rtl/soc_arbiter.sv
rtl/soc_mux.sv
rtl/soc_ram.sv
rtl/soc_timer.sv
rtl/soc_top.sv
tb/soc_chk.sv
tb/tb_soc.sv

//--- Makefile
TOP := tb_soc

all: run

obj_dir/V$(TOP): build.f $(wildcard rtl/*.sv tb/*.sv)
	verilator --binary --timing --timescale 1ns/100ps -Wno-fatal --top-module $(TOP) -f build.f

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "FAIL: see errors above" sim.log; then exit 1; fi
	@grep -q "PASS: all tests" sim.log

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/100ps --top-module $(TOP) -f build.f

clean:
	rm -rf obj_dir sim.log

.PHONY: all run lint clean

//--- tb/tb_soc.sv
`default_nettype none

module tb_soc;

   timeunit 1ns;
   timeprecision 100ps;

   localparam int TIMEOUT_CYCLES = 2000;   // about 4x the whole test run
   localparam int NUM_WORDS      = 32;

   localparam logic [soc_pkg::ADDR_W-1:0] GPIO_ADR  = 32'h4000_0000;
   localparam logic [soc_pkg::ADDR_W-1:0] TIMER_ADR = 32'h8000_0000;

   logic                        clk;
   logic                        rst_n;
   logic [soc_pkg::ADDR_W-1:0]  ibus_adr;
   logic                        ibus_cyc;
   logic [soc_pkg::DATA_W-1:0]  ibus_rdt;
   logic                        ibus_ack;
   logic [soc_pkg::ADDR_W-1:0]  dbus_adr;
   logic [soc_pkg::DATA_W-1:0]  dbus_dat;
   logic [soc_pkg::SEL_W-1:0]   dbus_sel;
   logic                        dbus_we;
   logic                        dbus_cyc;
   logic [soc_pkg::DATA_W-1:0]  dbus_rdt;
   logic                        dbus_ack;
   logic [soc_pkg::ADDR_W-1:0]  xbus_adr;
   logic [soc_pkg::DATA_W-1:0]  xbus_dat;
   logic [soc_pkg::SEL_W-1:0]   xbus_sel;
   logic                        xbus_we;
   logic                        xbus_cyc;
   logic [soc_pkg::DATA_W-1:0]  xbus_rdt;
   logic                        xbus_ack;
   logic                        gpio;
   logic                        timer_irq;

   int cycles = 0;   // posedges since start

   soc_top UUT (
      .i_wb_clk    (clk),
      .i_rst_n     (rst_n),
      .i_ibus_adr  (ibus_adr),
      .i_ibus_cyc  (ibus_cyc),
      .o_ibus_rdt  (ibus_rdt),
      .o_ibus_ack  (ibus_ack),
      .i_dbus_adr  (dbus_adr),
      .i_dbus_dat  (dbus_dat),
      .i_dbus_sel  (dbus_sel),
      .i_dbus_we   (dbus_we),
      .i_dbus_cyc  (dbus_cyc),
      .o_dbus_rdt  (dbus_rdt),
      .o_dbus_ack  (dbus_ack),
      .o_xbus_adr  (xbus_adr),
      .o_xbus_dat  (xbus_dat),
      .o_xbus_sel  (xbus_sel),
      .o_xbus_we   (xbus_we),
      .o_xbus_cyc  (xbus_cyc),
      .i_xbus_rdt  (xbus_rdt),
      .i_xbus_ack  (xbus_ack),
      .o_gpio      (gpio),
      .o_timer_irq (timer_irq)
   );

   always #4 clk = ~clk;   // 8 ns period

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= TIMEOUT_CYCLES) begin
         $display("timeout after %0d cycles, a bus handshake never finished", cycles);
         report_fail();
      end else if (UUT.u_chk.fail_count != 0) begin
         $display("a bus checker assertion failed");
         report_fail();
      end
   end

   // ----------------------------------------
   // error reporting and compare tasks
   // ----------------------------------------
   task automatic report_fail();
      $display("FAIL: see errors above");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_word(input string what, input logic [soc_pkg::DATA_W-1:0] got,
                             input logic [soc_pkg::DATA_W-1:0] exp);
      if (got !== exp) begin
         $display("[ERROR] %0t: %s got %h expected %h", $time, what, got, exp);
         report_fail();
      end
   endtask

   task automatic check_bit(input string what, input logic got, input logic exp);
      if (got !== exp) begin
         $display("[ERROR] %0t: %s got %b expected %b", $time, what, got, exp);
         report_fail();
      end
   endtask

   task automatic check_region_ack(input string what, input soc_pkg::region_e region,
                                   input int got, input int exp);
      if (got != exp) begin
         $display("[ERROR] %0t: %s in %s took %0d cycles expected %0d",
                  $time, what, region.name(), got, exp);
         report_fail();
      end
   endtask

   // ----------------------------------------
   // bus masters
   // ----------------------------------------
   function automatic logic [soc_pkg::ADDR_W-1:0] mem_word_adr(input int i);
      return soc_pkg::ADDR_W'(((i * 97) % soc_pkg::MEM_WORDS) * 4);   // spread over the RAM
   endfunction

   task automatic dbus_access(input logic [soc_pkg::ADDR_W-1:0] adr,
                              input logic [soc_pkg::DATA_W-1:0] dat,
                              input logic [soc_pkg::SEL_W-1:0] sel, input logic we,
                              output logic [soc_pkg::DATA_W-1:0] rdt, output int t_start);
      int lat;
      @(negedge clk);
      dbus_adr = adr;
      dbus_dat = dat;
      dbus_sel = sel;
      dbus_we  = we;
      dbus_cyc = 1'b1;
      t_start  = cycles;
      lat      = 0;
      do begin
         @(negedge clk);
         lat++;
      end while (!dbus_ack);
      rdt = dbus_rdt;
      check_region_ack("dbus ack", soc_pkg::region_e'(adr[soc_pkg::ADDR_W-1 -: 2]), lat, 1);
      @(negedge clk);   // cyc held through the ack cycle
      dbus_cyc = 1'b0;
      dbus_we  = 1'b0;
      check_bit("dbus ack single pulse", dbus_ack, 1'b0);
   endtask

   task automatic dbus_write(input logic [soc_pkg::ADDR_W-1:0] adr,
                             input logic [soc_pkg::DATA_W-1:0] dat,
                             input logic [soc_pkg::SEL_W-1:0] sel);
      logic [soc_pkg::DATA_W-1:0] unused_rdt;
      int unused_t;
      dbus_access(adr, dat, sel, 1'b1, unused_rdt, unused_t);
   endtask

   task automatic dbus_read(input logic [soc_pkg::ADDR_W-1:0] adr,
                            output logic [soc_pkg::DATA_W-1:0] rdt, output int t_start);
      dbus_access(adr, '0, 4'hf, 1'b0, rdt, t_start);
   endtask

   task automatic ibus_read(input logic [soc_pkg::ADDR_W-1:0] adr,
                            output logic [soc_pkg::DATA_W-1:0] rdt);
      int lat;
      @(negedge clk);
      ibus_adr = adr;
      ibus_cyc = 1'b1;
      lat      = 0;
      do begin
         @(negedge clk);
         lat++;
      end while (!ibus_ack);
      rdt = ibus_rdt;
      check_region_ack("ibus ack", soc_pkg::REG_MEM, lat, 1);
      @(negedge clk);
      ibus_cyc = 1'b0;
   endtask

   // both masters start in the same cycle
   task automatic dual_read(input logic [soc_pkg::ADDR_W-1:0] dadr,
                            input logic [soc_pkg::ADDR_W-1:0] iadr,
                            output logic [soc_pkg::DATA_W-1:0] d_rdt,
                            output logic [soc_pkg::DATA_W-1:0] i_rdt);
      int n;
      int d_at;
      int i_at;
      @(negedge clk);
      dbus_adr = dadr;
      dbus_sel = 4'hf;
      dbus_we  = 1'b0;
      dbus_cyc = 1'b1;
      ibus_adr = iadr;
      ibus_cyc = 1'b1;
      n    = 0;
      d_at = 0;
      i_at = 0;
      while (dbus_cyc || ibus_cyc) begin
         @(negedge clk);
         n++;
         if (d_at != 0)
            dbus_cyc = 1'b0;   // drop in the cycle after the ack
         else if (dbus_ack) begin
            d_at  = n;
            d_rdt = dbus_rdt;
         end
         if (i_at != 0)
            ibus_cyc = 1'b0;
         else if (ibus_ack) begin
            i_at  = n;
            i_rdt = ibus_rdt;
         end
      end
      check_region_ack("dbus ack on contention", soc_pkg::REG_MEM, d_at, 1);
      check_region_ack("ibus ack after dbus ack", soc_pkg::REG_MEM, i_at - d_at, 2);
   endtask

   // external slave answered by the testbench after a delay
   task automatic ext_access(input logic [soc_pkg::ADDR_W-1:0] adr,
                             input logic [soc_pkg::DATA_W-1:0] dat,
                             input logic [soc_pkg::SEL_W-1:0] sel, input logic we,
                             input logic [soc_pkg::DATA_W-1:0] rsp, input int delay);
      @(negedge clk);
      dbus_adr = adr;
      dbus_dat = dat;
      dbus_sel = sel;
      dbus_we  = we;
      dbus_cyc = 1'b1;
      for (int i = 0; i <= delay; i++) begin
         if (i == delay) begin
            xbus_rdt = rsp;
            xbus_ack = 1'b1;
         end
         #2;   // mid low phase
         check_bit("xbus cyc", xbus_cyc, 1'b1);
         check_word("xbus adr", xbus_adr, adr);
         check_word("xbus dat", xbus_dat, dat);
         check_word("xbus sel", soc_pkg::DATA_W'(xbus_sel), soc_pkg::DATA_W'(sel));
         check_bit("xbus we", xbus_we, we);
         check_bit("internal cyc during ext access",
                   UUT.mem_cyc | UUT.timer_cyc | UUT.u_mux.gpio_cyc, 1'b0);
         check_bit("dbus ack with xbus ack", dbus_ack, i == delay);
         if (i == delay)
            check_word("dbus rdt from xbus", dbus_rdt, rsp);
         @(negedge clk);
      end
      xbus_ack = 1'b0;
      dbus_cyc = 1'b0;
      dbus_we  = 1'b0;
   endtask

   // ----------------------------------------
   // directed tests
   // ----------------------------------------
   task automatic ram_byte_enables();
      logic [soc_pkg::DATA_W-1:0] model [NUM_WORDS];
      logic [soc_pkg::DATA_W-1:0] dat;
      logic [soc_pkg::DATA_W-1:0] rdt;
      logic [soc_pkg::SEL_W-1:0]  sel;
      int t;
      for (int i = 0; i < NUM_WORDS; i++) begin
         dat      = $urandom;
         model[i] = dat;
         dbus_write(mem_word_adr(i), dat, 4'hf);
      end
      for (int i = 0; i < NUM_WORDS; i++) begin
         dat = $urandom;
         sel = soc_pkg::SEL_W'($urandom % 15 + 1);   // never all zero
         for (int b = 0; b < soc_pkg::SEL_W; b++) begin
            if (sel[b])
               model[i][b*8 +: 8] = dat[b*8 +: 8];
         end
         dbus_write(mem_word_adr(i), dat, sel);
      end
      for (int i = 0; i < NUM_WORDS; i++) begin
         dbus_read(mem_word_adr(i), rdt, t);
         check_word("ram readback", rdt, model[i]);
      end
   endtask

   task automatic shared_memory();
      logic [soc_pkg::DATA_W-1:0] words [4];
      logic [soc_pkg::DATA_W-1:0] d_rdt;
      logic [soc_pkg::DATA_W-1:0] i_rdt;
      for (int j = 0; j < 4; j++) begin
         words[j] = $urandom;
         dbus_write(mem_word_adr(NUM_WORDS + j), words[j], 4'hf);
      end
      for (int j = 0; j < 4; j++) begin
         ibus_read(mem_word_adr(NUM_WORDS + j), i_rdt);
         check_word("ibus fetch", i_rdt, words[j]);
      end
      dual_read(mem_word_adr(NUM_WORDS), mem_word_adr(NUM_WORDS + 3), d_rdt, i_rdt);
      check_word("dbus read on contention", d_rdt, words[0]);
      check_word("ibus fetch on contention", i_rdt, words[3]);
   endtask

   task automatic gpio_bit();
      logic [soc_pkg::DATA_W-1:0] rdt;
      int t;
      dbus_write(GPIO_ADR, 32'h1, 4'hf);
      check_bit("gpio after write 1", gpio, 1'b1);
      dbus_read(GPIO_ADR, rdt, t);
      check_word("gpio read 1", rdt, 32'h1);
      dbus_write(GPIO_ADR, 32'h0, 4'hf);
      check_bit("gpio after write 0", gpio, 1'b0);
      dbus_read(GPIO_ADR, rdt, t);
      check_word("gpio read 0", rdt, 32'h0);
   endtask

   task automatic timer_compare();
      logic [soc_pkg::DATA_W-1:0] c1;
      logic [soc_pkg::DATA_W-1:0] c2;
      logic [soc_pkg::DATA_W-1:0] cmp;
      int t1;
      int t2;
      int gap;
      gap = 3 + int'($urandom % 10);
      dbus_read(TIMER_ADR, c1, t1);
      repeat (gap) @(negedge clk);
      dbus_read(TIMER_ADR, c2, t2);
      check_word("timer step", c2 - c1, soc_pkg::DATA_W'(t2 - t1));
      check_bit("irq before compare write", timer_irq, 1'b0);
      cmp = c2 + 20;
      dbus_write(TIMER_ADR, cmp, 4'hf);
      repeat (30) begin
         check_bit("timer irq", timer_irq, (cycles - t2) >= 20);   // counter at c2 + elapsed
         @(negedge clk);
      end
   endtask

   task automatic external_bus();
      logic [soc_pkg::ADDR_W-1:0] adr;
      for (int i = 0; i < 4; i++) begin
         adr = {2'b11, 30'($urandom)};
         ext_access(adr, $urandom, soc_pkg::SEL_W'($urandom), i[0], $urandom,
                    int'($urandom % 6));
      end
   endtask

   initial begin
      void'($urandom(32'h4f3abb74));
      clk      = 1'b0;
      rst_n    = 1'b0;
      ibus_adr = '0;
      ibus_cyc = 1'b0;
      dbus_adr = '0;
      dbus_dat = '0;
      dbus_sel = '0;
      dbus_we  = 1'b0;
      dbus_cyc = 1'b0;
      xbus_rdt = '0;
      xbus_ack = 1'b0;
      repeat (5) @(negedge clk);
      rst_n = 1'b1;

      ram_byte_enables();
      shared_memory();
      gpio_bit();
      timer_compare();
      external_bus();

      repeat (2) @(negedge clk);
      if (UUT.u_chk.fail_count == 0) begin
         $display("PASS: all tests");
         $finish;
      end else begin
         $display("a bus checker assertion failed");
         report_fail();
      end
   end

endmodule

`default_nettype wire

//--- tb/soc_chk.sv
`default_nettype none

module soc_chk (
   input logic                       i_clk,
   input logic                       i_rst_n,
   input logic                       i_ibus_cyc,
   input logic                       i_ibus_ack,
   input logic [soc_pkg::ADDR_W-1:0] i_dbus_adr,
   input logic                       i_dbus_we,
   input logic                       i_dbus_cyc,
   input logic                       i_dbus_ack,
   input logic                       i_xbus_cyc,
   input logic                       i_xbus_ack,
   input logic                       i_timer_irq
);

   timeunit 1ns;
   timeprecision 100ps;

   int unsigned fail_count = 0;   // assertion failures so far
   logic        timer_written;    // first timer write seen on the data bus

   always_ff @(posedge i_clk) begin
      if (!i_rst_n)
         timer_written <= 1'b0;
      else if (i_dbus_cyc & i_dbus_we &
               (i_dbus_adr[soc_pkg::ADDR_W-1 -: 2] == soc_pkg::REG_TIMER))
         timer_written <= 1'b1;
   end

   // ----------------------------------------
   // handshakes
   // ----------------------------------------
   a_ibus_ack_cyc: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      i_ibus_ack |-> i_ibus_cyc)
      else begin
         fail_count++;
         $error("ibus ack without cyc");
      end

   a_dbus_ack_cyc: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      i_dbus_ack |-> i_dbus_cyc)
      else begin
         fail_count++;
         $error("dbus ack without cyc");
      end

   a_xbus_ack_cyc: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      i_xbus_ack |-> i_xbus_cyc)
      else begin
         fail_count++;
         $error("xbus ack without cyc");
      end

   a_one_ack: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      !(i_ibus_ack && i_dbus_ack))
      else begin
         fail_count++;
         $error("ibus and dbus acked together");
      end

   a_irq_quiet: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      !timer_written |-> !i_timer_irq)
      else begin
         fail_count++;
         $error("timer irq before any timer write");
      end

endmodule

bind soc_top soc_chk u_chk (
   .i_clk       (i_wb_clk),
   .i_rst_n     (i_rst_n),
   .i_ibus_cyc  (i_ibus_cyc),
   .i_ibus_ack  (o_ibus_ack),
   .i_dbus_adr  (i_dbus_adr),
   .i_dbus_we   (i_dbus_we),
   .i_dbus_cyc  (i_dbus_cyc),
   .i_dbus_ack  (o_dbus_ack),
   .i_xbus_cyc  (o_xbus_cyc),
   .i_xbus_ack  (i_xbus_ack),
   .i_timer_irq (o_timer_irq)
);

`default_nettype wire

//--- rtl/soc_top.sv
`default_nettype none

module soc_top (
   input  logic                        i_wb_clk,
   input  logic                        i_rst_n,
   // instruction bus
   input  logic [soc_pkg::ADDR_W-1:0]  i_ibus_adr,
   input  logic                        i_ibus_cyc,
   output logic [soc_pkg::DATA_W-1:0]  o_ibus_rdt,
   output logic                        o_ibus_ack,
   // data bus
   input  logic [soc_pkg::ADDR_W-1:0]  i_dbus_adr,
   input  logic [soc_pkg::DATA_W-1:0]  i_dbus_dat,
   input  logic [soc_pkg::SEL_W-1:0]   i_dbus_sel,
   input  logic                        i_dbus_we,
   input  logic                        i_dbus_cyc,
   output logic [soc_pkg::DATA_W-1:0]  o_dbus_rdt,
   output logic                        o_dbus_ack,
   // external bus
   output logic [soc_pkg::ADDR_W-1:0]  o_xbus_adr,
   output logic [soc_pkg::DATA_W-1:0]  o_xbus_dat,
   output logic [soc_pkg::SEL_W-1:0]   o_xbus_sel,
   output logic                        o_xbus_we,
   output logic                        o_xbus_cyc,
   input  logic [soc_pkg::DATA_W-1:0]  i_xbus_rdt,
   input  logic                        i_xbus_ack,
   // peripherals
   output logic                        o_gpio,
   output logic                        o_timer_irq
);

   // internal response from the mux
   logic [soc_pkg::DATA_W-1:0] sbus_rdt;
   logic                       sbus_ack;

   // data side memory requests
   logic [soc_pkg::ADDR_W-1:0] dmem_adr;
   logic [soc_pkg::DATA_W-1:0] dmem_dat;
   logic [soc_pkg::SEL_W-1:0]  dmem_sel;
   logic                       dmem_we;
   logic                       dmem_cyc;
   logic [soc_pkg::DATA_W-1:0] dmem_rdt;
   logic                       dmem_ack;

   // arbitrated memory bus
   logic [soc_pkg::ADDR_W-1:0] mem_adr;
   logic [soc_pkg::DATA_W-1:0] mem_dat;
   logic [soc_pkg::SEL_W-1:0]  mem_sel;
   logic                       mem_we;
   logic                       mem_cyc;
   logic [soc_pkg::DATA_W-1:0] mem_rdt;
   logic                       mem_ack;

   logic [soc_pkg::DATA_W-1:0] timer_dat;
   logic                       timer_we;
   logic                       timer_cyc;
   logic [soc_pkg::DATA_W-1:0] timer_rdt;

   // ----------------------------------------
   // data bus decode
   // ----------------------------------------
   soc_mux u_mux (
      .i_clk       (i_wb_clk),
      .i_rst_n     (i_rst_n),
      .i_adr       (i_dbus_adr),
      .i_dat       (i_dbus_dat),
      .i_sel       (i_dbus_sel),
      .i_we        (i_dbus_we),
      .i_cyc       (i_dbus_cyc),
      .o_rdt       (sbus_rdt),
      .o_ack       (sbus_ack),
      .o_mem_adr   (dmem_adr),
      .o_mem_dat   (dmem_dat),
      .o_mem_sel   (dmem_sel),
      .o_mem_we    (dmem_we),
      .o_mem_cyc   (dmem_cyc),
      .i_mem_rdt   (dmem_rdt),
      .i_mem_ack   (dmem_ack),
      .o_timer_dat (timer_dat),
      .o_timer_we  (timer_we),
      .o_timer_cyc (timer_cyc),
      .i_timer_rdt (timer_rdt),
      .o_ext_cyc   (o_xbus_cyc),
      .o_gpio      (o_gpio)
   );

   soc_arbiter u_arbiter (
      .i_clk      (i_wb_clk),
      .i_rst_n    (i_rst_n),
      .i_dbus_adr (dmem_adr),
      .i_dbus_dat (dmem_dat),
      .i_dbus_sel (dmem_sel),
      .i_dbus_we  (dmem_we),
      .i_dbus_cyc (dmem_cyc),
      .o_dbus_rdt (dmem_rdt),
      .o_dbus_ack (dmem_ack),
      .i_ibus_adr (i_ibus_adr),
      .i_ibus_cyc (i_ibus_cyc),
      .o_ibus_rdt (o_ibus_rdt),
      .o_ibus_ack (o_ibus_ack),
      .o_mem_adr  (mem_adr),
      .o_mem_dat  (mem_dat),
      .o_mem_sel  (mem_sel),
      .o_mem_we   (mem_we),
      .o_mem_cyc  (mem_cyc),
      .i_mem_rdt  (mem_rdt),
      .i_mem_ack  (mem_ack)
   );

   soc_ram #(
      .DEPTH (soc_pkg::MEM_WORDS)
   ) u_ram (
      .i_clk   (i_wb_clk),
      .i_rst_n (i_rst_n),
      .i_adr   (mem_adr[$clog2(soc_pkg::MEM_WORDS)+1:2]),   // byte to word address
      .i_cyc   (mem_cyc),
      .i_we    (mem_we),
      .i_sel   (mem_sel),
      .i_dat   (mem_dat),
      .o_rdt   (mem_rdt),
      .o_ack   (mem_ack)
   );

   soc_timer u_timer (
      .i_clk   (i_wb_clk),
      .i_rst_n (i_rst_n),
      .i_cyc   (timer_cyc),
      .i_we    (timer_we),
      .i_dat   (timer_dat),
      .o_rdt   (timer_rdt),
      .o_irq   (o_timer_irq)
   );

   // ----------------------------------------
   // external bus and response merge
   // ----------------------------------------
   assign o_xbus_adr = i_dbus_adr;
   assign o_xbus_dat = i_dbus_dat;
   assign o_xbus_sel = i_dbus_sel;
   assign o_xbus_we  = i_dbus_we;

   // external ack takes priority
   assign o_dbus_rdt = i_xbus_ack ? i_xbus_rdt : sbus_rdt;
   assign o_dbus_ack = i_xbus_ack | sbus_ack;

endmodule

`default_nettype wire

//--- rtl/soc_timer.sv
`default_nettype none

module soc_timer (
   input  logic                        i_clk,
   input  logic                        i_rst_n,
   input  logic                        i_cyc,
   input  logic                        i_we,
   input  logic [soc_pkg::DATA_W-1:0]  i_dat,
   output logic [soc_pkg::DATA_W-1:0]  o_rdt,
   output logic                        o_irq
);

   logic [soc_pkg::DATA_W-1:0] count;
   logic [soc_pkg::DATA_W-1:0] compare;
   logic [soc_pkg::DATA_W-1:0] delta;
   logic                       armed;

   // ----------------------------------------
   // counter and compare
   // ----------------------------------------
   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         count <= '0;
         armed <= 1'b0;
      end else begin
         count <= count + 1'b1;   // free running, wraps
         if (i_cyc & i_we)
            armed <= 1'b1;
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_cyc & i_we)
         compare <= i_dat;
   end

   // wrap-safe compare via the sign of the difference
   assign delta = count - compare;
   assign o_irq = armed & ~delta[soc_pkg::DATA_W-1];

   assign o_rdt = count;

endmodule

`default_nettype wire

//--- rtl/soc_ram.sv
`default_nettype none

module soc_ram #(
   parameter int DEPTH = soc_pkg::MEM_WORDS
) (
   input  logic                        i_clk,
   input  logic                        i_rst_n,
   input  logic [$clog2(DEPTH)-1:0]    i_adr,   // word index
   input  logic                        i_cyc,
   input  logic                        i_we,
   input  logic [soc_pkg::SEL_W-1:0]   i_sel,
   input  logic [soc_pkg::DATA_W-1:0]  i_dat,
   output logic [soc_pkg::DATA_W-1:0]  o_rdt,
   output logic                        o_ack
);

   logic [soc_pkg::DATA_W-1:0] mem [DEPTH];

   // ----------------------------------------
   // byte lane writes
   // ----------------------------------------
   always_ff @(posedge i_clk) begin
      if (i_cyc & i_we & ~o_ack) begin
         for (int b = 0; b < soc_pkg::SEL_W; b++) begin
            if (i_sel[b])
               mem[i_adr][b*8 +: 8] <= i_dat[b*8 +: 8];
         end
      end
   end

   // old word on a write cycle
   always_ff @(posedge i_clk) begin
      o_rdt <= mem[i_adr];
   end

   // ack pulses one cycle, then a forced low cycle
   always_ff @(posedge i_clk) begin
      if (!i_rst_n)
         o_ack <= 1'b0;
      else
         o_ack <= i_cyc & ~o_ack;
   end

endmodule

`default_nettype wire

//--- rtl/soc_mux.sv
`default_nettype none

module soc_mux (
   input  logic                        i_clk,
   input  logic                        i_rst_n,
   // data side
   input  logic [soc_pkg::ADDR_W-1:0]  i_adr,
   input  logic [soc_pkg::DATA_W-1:0]  i_dat,
   input  logic [soc_pkg::SEL_W-1:0]   i_sel,
   input  logic                        i_we,
   input  logic                        i_cyc,
   output logic [soc_pkg::DATA_W-1:0]  o_rdt,
   output logic                        o_ack,
   // memory side
   output logic [soc_pkg::ADDR_W-1:0]  o_mem_adr,
   output logic [soc_pkg::DATA_W-1:0]  o_mem_dat,
   output logic [soc_pkg::SEL_W-1:0]   o_mem_sel,
   output logic                        o_mem_we,
   output logic                        o_mem_cyc,
   input  logic [soc_pkg::DATA_W-1:0]  i_mem_rdt,
   input  logic                        i_mem_ack,
   // timer side
   output logic [soc_pkg::DATA_W-1:0]  o_timer_dat,
   output logic                        o_timer_we,
   output logic                        o_timer_cyc,
   input  logic [soc_pkg::DATA_W-1:0]  i_timer_rdt,
   // external side
   output logic                        o_ext_cyc,
   // gpio
   output logic                        o_gpio
);

   soc_pkg::region_e region;

   logic                       gpio_cyc;
   logic                       periph_cyc;
   logic                       periph_ack;
   logic [soc_pkg::DATA_W-1:0] periph_rdt;

   // ----------------------------------------
   // region decode and cyc steering
   // ----------------------------------------
   assign region = soc_pkg::region_e'(i_adr[soc_pkg::ADDR_W-1 -: 2]);

   assign o_mem_cyc   = i_cyc & (region == soc_pkg::REG_MEM);
   assign gpio_cyc    = i_cyc & (region == soc_pkg::REG_GPIO);
   assign o_timer_cyc = i_cyc & (region == soc_pkg::REG_TIMER);
   assign o_ext_cyc   = i_cyc & (region == soc_pkg::REG_EXT);

   assign periph_cyc = gpio_cyc | o_timer_cyc;

   // memory passes straight through
   assign o_mem_adr = i_adr;
   assign o_mem_dat = i_dat;
   assign o_mem_sel = i_sel;
   assign o_mem_we  = i_we;

   assign o_timer_dat = i_dat;
   assign o_timer_we  = i_we;

   // ----------------------------------------
   // gpio bit and peripheral acks
   // ----------------------------------------
   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         o_gpio     <= 1'b0;
         periph_ack <= 1'b0;
      end else begin
         periph_ack <= periph_cyc & ~periph_ack;   // one ack per request
         if (gpio_cyc & i_we & ~periph_ack)
            o_gpio <= i_dat[0];
      end
   end

   // read data lands with the ack
   always_ff @(posedge i_clk) begin
      if (region == soc_pkg::REG_GPIO)
         periph_rdt <= {{(soc_pkg::DATA_W-1){1'b0}}, o_gpio};
      else
         periph_rdt <= i_timer_rdt;
   end

   assign o_rdt = (region == soc_pkg::REG_MEM) ? i_mem_rdt : periph_rdt;
   assign o_ack = i_mem_ack | periph_ack;   // ext ack merged at top

endmodule

`default_nettype wire

//--- rtl/soc_arbiter.sv
`default_nettype none

module soc_arbiter (
   input  logic                        i_clk,
   input  logic                        i_rst_n,
   // data side
   input  logic [soc_pkg::ADDR_W-1:0]  i_dbus_adr,
   input  logic [soc_pkg::DATA_W-1:0]  i_dbus_dat,
   input  logic [soc_pkg::SEL_W-1:0]   i_dbus_sel,
   input  logic                        i_dbus_we,
   input  logic                        i_dbus_cyc,
   output logic [soc_pkg::DATA_W-1:0]  o_dbus_rdt,
   output logic                        o_dbus_ack,
   // instruction side
   input  logic [soc_pkg::ADDR_W-1:0]  i_ibus_adr,
   input  logic                        i_ibus_cyc,
   output logic [soc_pkg::DATA_W-1:0]  o_ibus_rdt,
   output logic                        o_ibus_ack,
   // memory side
   output logic [soc_pkg::ADDR_W-1:0]  o_mem_adr,
   output logic [soc_pkg::DATA_W-1:0]  o_mem_dat,
   output logic [soc_pkg::SEL_W-1:0]   o_mem_sel,
   output logic                        o_mem_we,
   output logic                        o_mem_cyc,
   input  logic [soc_pkg::DATA_W-1:0]  i_mem_rdt,
   input  logic                        i_mem_ack
);

   logic busy;      // transaction in flight at the RAM
   logic owner_i;   // ibus holds the locked grant
   logic gnt_i;     // ibus is routed this cycle

   // dbus wins a tie when idle, locked owner otherwise
   assign gnt_i = busy ? owner_i : (i_ibus_cyc & ~i_dbus_cyc);

   assign o_mem_adr = gnt_i ? i_ibus_adr : i_dbus_adr;
   assign o_mem_dat = i_dbus_dat;   // don't care on fetches, we is low
   assign o_mem_sel = gnt_i ? {soc_pkg::SEL_W{1'b1}} : i_dbus_sel;
   assign o_mem_we  = ~gnt_i & i_dbus_we;   // fetches only read
   assign o_mem_cyc = gnt_i ? i_ibus_cyc : i_dbus_cyc;

   // ----------------------------------------
   // grant lock
   // ----------------------------------------
   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         busy    <= 1'b0;
         owner_i <= 1'b0;
      end else if (busy) begin
         if (i_mem_ack)
            busy <= 1'b0;   // release, next request waits a cycle
      end else if (o_mem_cyc) begin
         busy    <= 1'b1;
         owner_i <= gnt_i;
      end
   end

   assign o_dbus_rdt = i_mem_rdt;
   assign o_ibus_rdt = i_mem_rdt;
   assign o_dbus_ack = i_mem_ack & ~owner_i;
   assign o_ibus_ack = i_mem_ack & owner_i;

endmodule

`default_nettype wire

//--- rtl/soc_pkg.sv
`default_nettype none

package soc_pkg;

   // ----------------------------------------
   // bus widths
   // ----------------------------------------
   localparam int ADDR_W = 32;
   localparam int DATA_W = 32;
   localparam int SEL_W  = 4;   // one select per byte lane

   // ----------------------------------------
   // memory
   // ----------------------------------------
   localparam int MEM_WORDS = 2048;   // 8 KiB of 32-bit words

   // ----------------------------------------
   // data bus region map, adr[31:30]
   // ----------------------------------------
   typedef enum logic [1:0] {
      REG_MEM   = 2'b00,
      REG_GPIO  = 2'b01,
      REG_TIMER = 2'b10,
      REG_EXT   = 2'b11
   } region_e;

endpackage

`default_nettype wire
